//--- flist.f
+incdir+tests
source/blend_pkg.sv
source/pixel_unpack.sv
source/blend_mac.sv
source/pixel_out.sv
source/video_blend.sv
tests/video_blend_tb.sv

//--- Makefile
# Verilator build and run for the video blend pipeline

VERILATOR  ?= verilator
TOP        ?= video_blend_tb
RTL_TOP    ?= video_blend
FLIST      ?= flist.f
BUILD_DIR  ?= build
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

SOURCES := $(wildcard source/*.sv tests/*.sv tests/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# exit status of the binary is the test result
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/blend_model.svh
`ifndef BLEND_MODEL_SVH
`define BLEND_MODEL_SVH

// reference blend worked in plain integers
// fields of a word: alpha 15..12, r 11..8, g 7..4, b 3..0

// a 4 bit field spread over 8 bits, N times 17 gives 0xNN
function automatic int widen_field(input int field);
    return field * 17;
endfunction

// weight on colour A
function automatic int weight_of_a(input argb_t a, input argb_t b);
    int w;
    if (a[A_OPAQUE_BIT]) begin
        w = 255;                                        // A opaque
    end else begin
        w = widen_field(15 - int'(b[15:12]));           // complement of B alpha
    end
    return w;
endfunction

// weight on colour B
function automatic int weight_of_b(input argb_t a, input argb_t b);
    int w;
    if (a[A_HIDE_B_BIT]) begin
        w = 0;                                          // B hidden by A
    end else begin
        w = widen_field(int'(b[15:12]));
    end
    return w;
endfunction

// 8x8 product, only its top 7 of 16 bits survive
function automatic int weighted_half(input int field, input int weight);
    return (widen_field(field) * weight) / 512;
endfunction

// sums of 128 and up read full scale
function automatic int clamp_channel(input int total);
    int c;
    if (total >= 128) begin
        c = 15;
    end else begin
        c = (total / 8) % 16;                           // sum bits 6..3
    end
    return c;
endfunction

// expected output colour while de is high
function automatic rgb_t expected_rgb(input argb_t a, input argb_t b);
    int   wa;
    int   wb;
    int   total;
    rgb_t rgb;
    wa  = weight_of_a(a, b);
    wb  = weight_of_b(a, b);
    rgb = '0;
    for (int ch = 0; ch < 3; ch++) begin                // b, g, r from the bottom up
        total = weighted_half(int'(a[4*ch +: 4]), wa)
              + weighted_half(int'(b[4*ch +: 4]), wb);
        rgb[4*ch +: 4] = 4'(clamp_channel(total));
    end
    return rgb;
endfunction

`endif

//--- tests/video_blend_tb.sv
`default_nettype none
`timescale 1ns/10ps

// random and directed pixels through the blend pipe, checked against the model
module video_blend_tb
    import blend_pkg::*;
();

`include "blend_model.svh"

localparam int          CLK_HALF_NS        = 50;            // 100 ns pixel clock
localparam int          RESET_CYCLES       = 2;
localparam int          PIPE_DEPTH         = 3;             // timing in to timing out
localparam int          N_DIRECTED         = 8;
localparam int          N_RANDOM           = 3000;
localparam int          N_PIXELS           = N_DIRECTED + N_RANDOM;
localparam int          EDGE_TIMEOUT_POLLS = 4 * CLK_HALF_NS;   // 1 ns polls
localparam logic [31:0] LCG_SEED           = 32'd35;

// hand picked pixels ahead of the random stream
localparam argb_t DIR_A [N_DIRECTED] = '{
    16'h0C84,                                               // plain blend
    16'h0FFF,                                               // B alpha F, A weight zero
    16'h8FFF,                                               // opaque A plus full B
    16'h8123,                                               // opaque A, dim
    16'h4ABC,                                               // A hides B
    16'hC5F0,                                               // both flags
    16'h8FFF,                                               // bright, blanked
    16'h0000                                                // black A over B
};
localparam argb_t DIR_B [N_DIRECTED] = '{
    16'h7F0F,
    16'hFFFF,
    16'hFFFF,                                               // overflows every channel
    16'h3456,
    16'hF999,
    16'hFFFF,
    16'hFFFF,
    16'h8FFF
};
localparam logic [N_DIRECTED-1:0] DIR_DE = 8'hBF;          // pixel 6 has de low

typedef struct packed {
    video_timing_t  timing;                                 // timing_o expected
    rgb_t           rgb;                                    // blend_rgb_o expected
} expect_t;

logic           clk = 1'b0;
logic           rst_i;
video_timing_t  timing_i;
argb_t          color_a_i;
argb_t          color_b_i;
video_timing_t  timing_o;
rgb_t           blend_rgb_o;

argb_t          stim_a [N_PIXELS];                          // colour A per pixel
argb_t          stim_b [N_PIXELS];                          // colour B per pixel
video_timing_t  stim_t [N_PIXELS];                          // timing per pixel
expect_t        exp_q [$];                                  // outputs still in flight
logic [31:0]    lcg_state;
video_timing_t  pending_timing;                             // timing waiting for its colour

video_blend dut (
    .clk         (clk),
    .rst_i       (rst_i),
    .timing_i    (timing_i),
    .color_a_i   (color_a_i),
    .color_b_i   (color_b_i),
    .timing_o    (timing_o),
    .blend_rgb_o (blend_rgb_o)
);

initial begin
    forever #(CLK_HALF_NS) clk = ~clk;
end

// upper half of a 32 bit LCG step
function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
endfunction

task automatic build_stimulus();
    logic [15:0] ctl;
    for (int i = 0; i < N_DIRECTED; i++) begin
        stim_a[i] = DIR_A[i];
        stim_b[i] = DIR_B[i];
        stim_t[i] = '{vsync: i[1], hsync: i[0], de: DIR_DE[i]};
    end
    for (int i = N_DIRECTED; i < N_PIXELS; i++) begin
        stim_a[i] = next_random();                          // flags random too
        stim_b[i] = next_random();
        ctl       = next_random();
        stim_t[i] = '{vsync: ctl[8], hsync: ctl[4], de: (ctl[1:0] != 2'b00)};
    end
endtask

task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "run stopped at the first failure");
endtask

task automatic report_mismatch(input string what, input logic [15:0] got,
                               input logic [15:0] want);
    $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, want);
    abort_run();
endtask

// polls off the edge grid, returns 1 ns after the next rising edge
task automatic wait_clock_edge();
    logic prev;
    int   polls;
    prev  = clk;
    polls = 0;
    #0.5;
    while (!(prev === 1'b0 && clk === 1'b1)) begin
        prev = clk;
        #1;
        polls++;
        if (polls > EDGE_TIMEOUT_POLLS) begin
            $display("no rising clock edge seen within %0d ns, clock has stopped", polls);
            abort_run();
        end
    end
    #0.5;
endtask

task automatic check_outputs();
    expect_t e;
    if (exp_q.size() == 0) begin
        $display("expected output queue ran empty while the pipe was still running");
        abort_run();
    end
    e = exp_q.pop_front();
    assert (timing_o === e.timing)
        else report_mismatch("timing_o", 16'(timing_o), 16'(e.timing));
    assert (blend_rgb_o === e.rgb)
        else report_mismatch("blend_rgb_o", 16'(blend_rgb_o), 16'(e.rgb));
endtask

// colour for the pixel whose timing went in last cycle, timing for the next one
task automatic run_cycle(input argb_t a, input argb_t b, input video_timing_t next_t);
    expect_t e;
    wait_clock_edge();
    check_outputs();
    color_a_i = a;
    color_b_i = b;
    e.timing  = pending_timing;
    if (pending_timing.de) begin
        e.rgb = expected_rgb(a, b);
    end else begin
        e.rgb = '0;                                         // blanked
    end
    exp_q.push_back(e);
    timing_i       = next_t;
    pending_timing = next_t;
endtask

initial begin
    video_timing_t next_t;
    rst_i          = 1'b1;
    timing_i       = '0;
    color_a_i      = '0;
    color_b_i      = '0;
    pending_timing = '0;
    lcg_state      = LCG_SEED;
    build_stimulus();

    for (int i = 0; i < RESET_CYCLES; i++) begin
        wait_clock_edge();
        assert (timing_o === '0 && blend_rgb_o === '0)
            else report_mismatch("output in reset", 16'({timing_o, blend_rgb_o}), 16'h0);
    end
    rst_i = 1'b0;

    // cleared registers drain out first
    for (int i = 0; i < PIPE_DEPTH; i++) begin
        exp_q.push_back('0);
    end
    timing_i       = stim_t[0];
    pending_timing = stim_t[0];

    for (int i = 0; i < N_PIXELS; i++) begin
        if (i + 1 < N_PIXELS) begin
            next_t = stim_t[i + 1];
        end else begin
            next_t = '0;                                    // idle after the last pixel
        end
        run_cycle(stim_a[i], stim_b[i], next_t);
    end
    for (int i = 0; i < PIPE_DEPTH; i++) begin
        run_cycle('0, '0, '0);                              // flush the last pixels
    end

    $display("Finished with no errors");
    $finish;
end

endmodule

`default_nettype wire

//--- source/video_blend.sv
`default_nettype none
`timescale 1ns/10ps

// two layer alpha blend for the video output path
// colour words trail their timing by one clock from the palette RAM
module video_blend
    import blend_pkg::*;
(
    input  wire logic               clk,            // pixel clock
    input  wire logic               rst_i,          // sync reset, active high
    input  wire video_timing_t      timing_i,       // vsync hsync de
    input  wire argb_t              color_a_i,      // colour A, one clock late
    input  wire argb_t              color_b_i,      // colour B, one clock late
    output      video_timing_t      timing_o,       // delayed timing
    output      rgb_t               blend_rgb_o     // blended colour
);

blend_operands_t    operands;                       // unpack to mac
blend_sums_t        sums;                           // mac to output

// nibble expand and alpha select
pixel_unpack u_unpack (
    .clk        (clk),
    .rst_i      (rst_i),
    .color_a_i  (color_a_i),
    .color_b_i  (color_b_i),
    .operands_o (operands)
);

// weight and add
blend_mac u_mac (
    .clk        (clk),
    .rst_i      (rst_i),
    .operands_i (operands),
    .sums_o     (sums)
);

// delay timing, clamp, blank
pixel_out u_out (
    .clk        (clk),
    .rst_i      (rst_i),
    .timing_i   (timing_i),                         // bypasses the colour stages
    .sums_i     (sums),
    .timing_o   (timing_o),
    .blend_rgb_o(blend_rgb_o)
);

endmodule

`default_nettype wire

//--- source/pixel_out.sv
`default_nettype none
`timescale 1ns/10ps

// output side, timing delay line plus saturate and blank
module pixel_out
    import blend_pkg::*;
(
    input  wire logic               clk,            // pixel clock
    input  wire logic               rst_i,          // sync reset, active high
    input  wire video_timing_t      timing_i,       // raw timing from the top
    input  wire blend_sums_t        sums_i,         // sums from blend_mac
    output      video_timing_t      timing_o,       // timing aligned with colour
    output      rgb_t               blend_rgb_o     // final 12 bit colour
);

// clamp an 8 bit sum to one output nibble
function automatic nibble_t saturate(input sum_t s);
    nibble_t n;                                     // clamped channel
    if (s[CHANNEL_W-1]) begin
        n = {NIBBLE_W{1'b1}};                       // overflow reads F
    end else begin
        n = s[CHANNEL_W-2 -: NIBBLE_W];             // bits 6..3
    end
    return n;
endfunction

video_timing_t  timing_s;                           // sampled with the pixel's timing
video_timing_t  timing_d1;                          // waits for the palette colour
video_timing_t  timing_d2;                          // sits beside the sums, de blanks
rgb_t           rgb_next;                           // colour before the output register

// black outside the active area, else clamp each channel
always_comb begin
    if (timing_d2.de) begin
        rgb_next = {saturate(sums_i.r),
                    saturate(sums_i.g),
                    saturate(sums_i.b)};
    end else begin
        rgb_next = '0;                              // blanking
    end
end

// timing walks four registers, colour joins it on the last one
always_ff @(posedge clk) begin
    if (rst_i) begin
        timing_s    <= '0;                          // syncs and de inactive
        timing_d1   <= '0;
        timing_d2   <= '0;
        timing_o    <= '0;
        blend_rgb_o <= '0;                          // black until data arrives
    end else begin
        timing_s    <= timing_i;                    // same edge as timing sample
        timing_d1   <= timing_s;                    // colour regs load now
        timing_d2   <= timing_d1;                   // sums load now
        timing_o    <= timing_d2;                   // leaves with blend_rgb_o
        blend_rgb_o <= rgb_next;
    end
end

endmodule

`default_nettype wire

//--- source/blend_mac.sv
`default_nettype none
`timescale 1ns/10ps

// weight both colours and add them per channel
module blend_mac
    import blend_pkg::*;
(
    input  wire logic               clk,            // pixel clock
    input  wire logic               rst_i,          // sync reset, active high
    input  wire blend_operands_t    operands_i,     // channels and alphas
    output      blend_sums_t        sums_o          // registered per channel sums
);

// A*alpha_a + B*alpha_b on the top 7 bits of each product
function automatic sum_t weigh_add(
    input channel_t ch_a,
    input channel_t al_a,
    input channel_t ch_b,
    input channel_t al_b
);
    logic [PRODUCT_W-1:0] prod_a;                   // 8x8 unsigned product for A
    logic [PRODUCT_W-1:0] prod_b;                   // 8x8 unsigned product for B
    prod_a = PRODUCT_W'(ch_a) * PRODUCT_W'(al_a);
    prod_b = PRODUCT_W'(ch_b) * PRODUCT_W'(al_b);
    // each half is at most 127, so bit 7 of the sum is the overflow
    return sum_t'(prod_a[PRODUCT_W-1:PRODUCT_KEEP_LSB])
         + sum_t'(prod_b[PRODUCT_W-1:PRODUCT_KEEP_LSB]);
endfunction

blend_sums_t    sums_next;                          // unregistered sums

always_comb begin
    sums_next.r = weigh_add(operands_i.color_a.r, operands_i.alpha_a,
                            operands_i.color_b.r, operands_i.alpha_b);   // red
    sums_next.g = weigh_add(operands_i.color_a.g, operands_i.alpha_a,
                            operands_i.color_b.g, operands_i.alpha_b);   // green
    sums_next.b = weigh_add(operands_i.color_a.b, operands_i.alpha_a,
                            operands_i.color_b.b, operands_i.alpha_b);   // blue
end

// one register after the multipliers, second colour stage
always_ff @(posedge clk) begin
    if (rst_i) begin
        sums_o  <= '0;                              // zero sums out of reset
    end else begin
        sums_o  <= sums_next;
    end
end

endmodule

`default_nettype wire

//--- source/pixel_unpack.sv
`default_nettype none
`timescale 1ns/10ps

// input stage of the blend pipe
// colours come from the palette RAM, so they trail their timing by one clock
module pixel_unpack
    import blend_pkg::*;
(
    input  wire logic               clk,            // pixel clock
    input  wire logic               rst_i,          // sync reset, active high
    input  wire argb_t              color_a_i,      // colour A word
    input  wire argb_t              color_b_i,      // colour B word
    output      blend_operands_t    operands_o      // registered channels and alphas
);

// repeat the nibble so F maps to FF and 0 to 00
function automatic channel_t expand(input nibble_t n);
    return {n, n};                                  // 0xN becomes 0xNN
endfunction

nibble_t            a_r;                            // colour A red field
nibble_t            a_g;                            // colour A green field
nibble_t            a_b;                            // colour A blue field
nibble_t            b_r;                            // colour B red field
nibble_t            b_g;                            // colour B green field
nibble_t            b_b;                            // colour B blue field
nibble_t            b_alpha;                        // colour B alpha field
logic               a_opaque;                       // A bit 15
logic               a_hide_b;                       // A bit 14
blend_operands_t    operands_next;                  // next operand word

// field split, alpha on top then r g b
assign a_r      = color_a_i[2*NIBBLE_W +: NIBBLE_W];
assign a_g      = color_a_i[1*NIBBLE_W +: NIBBLE_W];
assign a_b      = color_a_i[0*NIBBLE_W +: NIBBLE_W];
assign b_r      = color_b_i[2*NIBBLE_W +: NIBBLE_W];
assign b_g      = color_b_i[1*NIBBLE_W +: NIBBLE_W];
assign b_b      = color_b_i[0*NIBBLE_W +: NIBBLE_W];
assign b_alpha  = color_b_i[3*NIBBLE_W +: NIBBLE_W];   // only B alpha drives the weights
assign a_opaque = color_a_i[A_OPAQUE_BIT];
assign a_hide_b = color_a_i[A_HIDE_B_BIT];

always_comb begin
    operands_next.color_a.r = expand(a_r);          // A channels
    operands_next.color_a.g = expand(a_g);
    operands_next.color_a.b = expand(a_b);

    operands_next.color_b.r = expand(b_r);          // B channels
    operands_next.color_b.g = expand(b_g);
    operands_next.color_b.b = expand(b_b);

    // A weight is the complement of B alpha unless A is opaque
    if (a_opaque) begin
        operands_next.alpha_a = ALPHA_FULL;         // A at full weight
    end else begin
        operands_next.alpha_a = expand(~b_alpha);   // 1 minus B alpha
    end

    // B weight is its own alpha unless A hides it
    if (a_hide_b) begin
        operands_next.alpha_b = ALPHA_NONE;         // B drops out
    end else begin
        operands_next.alpha_b = expand(b_alpha);
    end
end

// colours land here one edge after their timing was sampled
always_ff @(posedge clk) begin
    if (rst_i) begin
        operands_o  <= '0;                          // black, zero weights
    end else begin
        operands_o  <= operands_next;
    end
end

endmodule

`default_nettype wire

//--- source/blend_pkg.sv
`default_nettype none

package blend_pkg;

// field and datapath widths
localparam int NIBBLE_W         = 4;    // one argb field
localparam int CHANNEL_W        = 8;    // expanded channel or alpha
localparam int PRODUCT_W        = 16;   // channel times alpha

// the blend keeps product bits 15..9, so 7 bits per side
localparam int PRODUCT_KEEP_LSB = 9;    // lowest product bit kept

// flag bits in colour A, above the channel fields
localparam int A_OPAQUE_BIT     = 15;   // forces alpha_a to full
localparam int A_HIDE_B_BIT     = 14;   // forces alpha_b to zero

// plain vectors
typedef logic [NIBBLE_W-1:0]   nibble_t;    // one 4 bit field
typedef logic [CHANNEL_W-1:0]  channel_t;   // 8 bit channel or alpha
typedef logic [4*NIBBLE_W-1:0] argb_t;      // alpha in [15:12], r g b below
typedef logic [3*NIBBLE_W-1:0] rgb_t;       // 12 bit output colour
typedef logic [CHANNEL_W-1:0]  sum_t;       // top bit flags overflow

// alpha constants
localparam channel_t ALPHA_FULL = 8'hFF;    // colour at full weight
localparam channel_t ALPHA_NONE = 8'h00;    // colour dropped

// sync and display enable, kept together through the delay line
typedef struct packed {
    logic       vsync;                      // vertical sync
    logic       hsync;                      // horizontal sync
    logic       de;                         // display enable
} video_timing_t;

// one colour after nibble expansion
typedef struct packed {
    channel_t   r;                          // red
    channel_t   g;                          // green
    channel_t   b;                          // blue
} rgb_channels_t;

// everything the multiply stage needs for one pixel
typedef struct packed {
    rgb_channels_t  color_a;                // colour A channels
    rgb_channels_t  color_b;                // colour B channels
    channel_t       alpha_a;                // weight for A
    channel_t       alpha_b;                // weight for B
} blend_operands_t;

// per channel sums of the two weighted colours
typedef struct packed {
    sum_t       r;                          // red sum
    sum_t       g;                          // green sum
    sum_t       b;                          // blue sum
} blend_sums_t;

endpackage

`default_nettype wire
